/* Bender.yml */
package:
  name: wb_soc

sources:
  - hdl/wb_bus_pkg.sv
  - hdl/soc_map_pkg.sv
  - hdl/wb_addr_decode.sv
  - hdl/wb_dual_port_ram.sv
  - hdl/wb_mtime_regs.sv
  - hdl/wb_resp_mux.sv
  - hdl/wb_soc_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/wb_soc_tb.sv

/* flist.f */
+incdir+verification
hdl/wb_bus_pkg.sv
hdl/soc_map_pkg.sv
hdl/wb_addr_decode.sv
hdl/wb_dual_port_ram.sv
hdl/wb_mtime_regs.sv
hdl/wb_resp_mux.sv
hdl/wb_soc_top.sv
verification/wb_soc_tb.sv

/* hdl/soc_map_pkg.sv */
`default_nettype none

package soc_map_pkg;

    // shared RAM, code window first then data
    localparam logic [31:0] RESET_VECTOR = 32'h0001_0000;
    localparam int          RAM_ADDR_W   = 13;
    localparam logic [31:0] CODE_END     = RESET_VECTOR + 32'h0000_6FFF;
    localparam logic [31:0] RAM_END      = RESET_VECTOR + 32'h0000_7FFF;

    // machine timer window
    localparam logic [31:0] TIMER_BASE = 32'h0000_8000;
    localparam logic [31:0] TIMER_END  = 32'h0000_800F;

    // timer register offsets inside the window
    localparam logic [3:0] MTIME_LO_OFS    = 4'h0;
    localparam logic [3:0] MTIME_HI_OFS    = 4'h4;
    localparam logic [3:0] MTIMECMP_LO_OFS = 4'h8;
    localparam logic [3:0] MTIMECMP_HI_OFS = 4'hC;

    // data-port slave indices
    localparam int SLV_RAM         = 0;
    localparam int SLV_TIMER       = 1;
    localparam int NUM_DATA_SLAVES = 2;

endpackage

`default_nettype wire

/* hdl/wb_addr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_addr_decode (
    input  wire logic                                    wb_clk_i,
    input  wire logic                                    arst_n_i,
    input  wire wb_bus_pkg::wb_req_t                     req_i,
    output logic [soc_map_pkg::NUM_DATA_SLAVES-1:0]      slv_stb_o,
    output logic [soc_map_pkg::NUM_DATA_SLAVES:0]        sel_q_o
);

    import soc_map_pkg::*;

    logic req_valid;
    logic ram_hit;
    logic tmr_hit;
    logic miss;

    assign req_valid = req_i.cyc & req_i.stb;

    // window compares, inclusive at both ends
    assign ram_hit = (req_i.adr >= RESET_VECTOR) && (req_i.adr <= RAM_END);
    assign tmr_hit = (req_i.adr >= TIMER_BASE) && (req_i.adr <= TIMER_END);

    always_comb
    begin
        slv_stb_o            = '0;
        slv_stb_o[SLV_RAM]   = req_valid & ram_hit;
        slv_stb_o[SLV_TIMER] = req_valid & tmr_hit;
    end

    // nobody claims a valid request
    assign miss = req_valid & ~ram_hit & ~tmr_hit;

    // selection for the response cycle, miss flag on top
    always_ff @(posedge wb_clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            sel_q_o <= '0;
        end
        else
        begin
            sel_q_o <= {miss, slv_stb_o};
        end
    end

endmodule

`default_nettype wire

/* hdl/wb_bus_pkg.sv */
`default_nettype none

package wb_bus_pkg;

    // bus widths
    localparam int WB_ADDR_W = 32;
    localparam int WB_DATA_W = 32;
    localparam int WB_SEL_W  = WB_DATA_W / 8;

    // one request as driven by a master, 71 bits
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [WB_ADDR_W-1:0] adr;
        logic [WB_DATA_W-1:0] dat;
        logic [WB_SEL_W-1:0]  sel;
    } wb_req_t;

    // one response as returned by a slave, 35 bits
    typedef struct packed {
        logic                 ack;
        logic                 err;
        logic                 stall;
        logic [WB_DATA_W-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

/* hdl/wb_dual_port_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_dual_port_ram (
    input  wire logic                wb_clk_i,
    input  wire logic                arst_n_i,
    input  wire wb_bus_pkg::wb_req_t p0_req_i,
    output wb_bus_pkg::wb_rsp_t      p0_rsp_o,
    input  wire logic                p1_stb_i,
    input  wire wb_bus_pkg::wb_req_t p1_req_i,
    output wb_bus_pkg::wb_rsp_t      p1_rsp_o
);

    import wb_bus_pkg::*;
    import soc_map_pkg::*;

    localparam int DEPTH = 2 ** RAM_ADDR_W;

    logic [WB_DATA_W-1:0] mem [DEPTH];

    logic [RAM_ADDR_W-1:0] p0_idx;
    logic [RAM_ADDR_W-1:0] p1_idx;
    logic                  p0_valid;
    logic                  p0_hit;

    logic                 p0_ack_q;
    logic                 p0_err_q;
    logic [WB_DATA_W-1:0] p0_dat_q;
    logic                 p1_ack_q;
    logic [WB_DATA_W-1:0] p1_dat_q;

    // word index sits above the byte offset
    assign p0_idx = p0_req_i.adr[RAM_ADDR_W+1:2];
    assign p1_idx = p1_req_i.adr[RAM_ADDR_W+1:2];

    // fetch port is read-only and limited to the code window
    assign p0_valid = p0_req_i.cyc & p0_req_i.stb;
    assign p0_hit   = p0_valid & ~p0_req_i.we
                      & (p0_req_i.adr >= RESET_VECTOR) & (p0_req_i.adr <= CODE_END);

    // storage and read data, port 0 sees old contents on a collision
    always_ff @(posedge wb_clk_i)
    begin
        if (p1_stb_i && p1_req_i.we)
        begin
            for (int b = 0; b < WB_SEL_W; b++)
            begin
                if (p1_req_i.sel[b])
                    mem[p1_idx][8*b +: 8] <= p1_req_i.dat[8*b +: 8];
            end
        end
        if (p1_stb_i)
            p1_dat_q <= mem[p1_idx];
        if (p0_hit)
            p0_dat_q <= mem[p0_idx];
        else if (p0_valid)
            p0_dat_q <= '0;
    end

    always_ff @(posedge wb_clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            p0_ack_q <= 1'b0;
            p0_err_q <= 1'b0;
            p1_ack_q <= 1'b0;
        end
        else
        begin
            p0_ack_q <= p0_hit;
            p0_err_q <= p0_valid & ~p0_hit;
            p1_ack_q <= p1_stb_i;
        end
    end

    always_comb
    begin
        p0_rsp_o.ack   = p0_ack_q;
        p0_rsp_o.err   = p0_err_q;
        p0_rsp_o.stall = 1'b0;
        p0_rsp_o.dat   = p0_dat_q;

        // data port never errors, decoding already filtered it
        p1_rsp_o.ack   = p1_ack_q;
        p1_rsp_o.err   = 1'b0;
        p1_rsp_o.stall = 1'b0;
        p1_rsp_o.dat   = p1_dat_q;
    end

endmodule

`default_nettype wire

/* hdl/wb_mtime_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_mtime_regs (
    input  wire logic                wb_clk_i,
    input  wire logic                arst_n_i,
    input  wire logic                stb_i,
    input  wire wb_bus_pkg::wb_req_t req_i,
    output wb_bus_pkg::wb_rsp_t      rsp_o,
    output logic                     mtip_o
);

    import wb_bus_pkg::*;
    import soc_map_pkg::*;

    logic [63:0] mtime_q;
    logic [63:0] mtime_d;
    logic [63:0] mtimecmp_q;
    logic [63:0] mtimecmp_d;
    logic [3:0]  reg_ofs;
    logic        wr_en;

    logic                 ack_q;
    logic                 mtip_q;
    logic [WB_DATA_W-1:0] rd_data;
    logic [WB_DATA_W-1:0] dat_q;

    // byte lane merge of a write into one 32-bit half
    function automatic logic [WB_DATA_W-1:0] merge_bytes(
        input logic [WB_DATA_W-1:0] old_w,
        input logic [WB_DATA_W-1:0] new_w,
        input logic [WB_SEL_W-1:0]  sel
    );
        logic [WB_DATA_W-1:0] res;
        res = old_w;
        for (int b = 0; b < WB_SEL_W; b++)
        begin
            if (sel[b])
                res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    // word aligned offset, low address bits ignored
    assign reg_ofs = {req_i.adr[3:2], 2'b00};
    assign wr_en   = stb_i & req_i.we;

    always_comb
    begin
        mtime_d    = mtime_q + 64'd1;
        mtimecmp_d = mtimecmp_q;
        if (wr_en)
        begin
            case (reg_ofs)
                MTIME_LO_OFS:
                    mtime_d = {mtime_q[63:32], merge_bytes(mtime_q[31:0], req_i.dat, req_i.sel)};
                MTIME_HI_OFS:
                    mtime_d = {merge_bytes(mtime_q[63:32], req_i.dat, req_i.sel), mtime_q[31:0]};
                MTIMECMP_LO_OFS:
                    mtimecmp_d[31:0] = merge_bytes(mtimecmp_q[31:0], req_i.dat, req_i.sel);
                default:
                    mtimecmp_d[63:32] = merge_bytes(mtimecmp_q[63:32], req_i.dat, req_i.sel);
            endcase
        end
    end

    // reads see the values before this edge
    always_comb
    begin
        case (reg_ofs)
            MTIME_LO_OFS:    rd_data = mtime_q[31:0];
            MTIME_HI_OFS:    rd_data = mtime_q[63:32];
            MTIMECMP_LO_OFS: rd_data = mtimecmp_q[31:0];
            default:         rd_data = mtimecmp_q[63:32];
        endcase
    end

    always_ff @(posedge wb_clk_i)
    begin
        if (stb_i)
            dat_q <= rd_data;
    end

    always_ff @(posedge wb_clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;
            ack_q      <= 1'b0;
            mtip_q     <= 1'b0;
        end
        else
        begin
            mtime_q    <= mtime_d;
            mtimecmp_q <= mtimecmp_d;
            ack_q      <= stb_i;
            mtip_q     <= (mtime_q >= mtimecmp_q);
        end
    end

    assign mtip_o = mtip_q;

    always_comb
    begin
        rsp_o.ack   = ack_q;
        rsp_o.err   = 1'b0;
        rsp_o.stall = 1'b0;
        rsp_o.dat   = dat_q;
    end

endmodule

`default_nettype wire

/* hdl/wb_resp_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_resp_mux (
    input  wire logic [soc_map_pkg::NUM_DATA_SLAVES:0] sel_q_i,
    input  wire wb_bus_pkg::wb_rsp_t                  ram_rsp_i,
    input  wire wb_bus_pkg::wb_rsp_t                  tmr_rsp_i,
    output wb_bus_pkg::wb_rsp_t                       rsp_o
);

    import soc_map_pkg::*;

    localparam int MISS_BIT = NUM_DATA_SLAVES;

    // at most one selection bit is set, decided a cycle earlier
    always_comb
    begin
        rsp_o = '0;
        if (sel_q_i[MISS_BIT])
        begin
            // unmapped access, error with zero data
            rsp_o.err = 1'b1;
        end
        else if (sel_q_i[SLV_RAM])
        begin
            rsp_o = ram_rsp_i;
        end
        else if (sel_q_i[SLV_TIMER])
        begin
            rsp_o = tmr_rsp_i;
        end
    end

endmodule

`default_nettype wire

/* hdl/wb_soc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_soc_top (
    input  wire logic                wb_clk_i,
    input  wire logic                arst_n_i,
    input  wire wb_bus_pkg::wb_req_t inst_req_i,
    output wb_bus_pkg::wb_rsp_t      inst_rsp_o,
    input  wire wb_bus_pkg::wb_req_t data_req_i,
    output wb_bus_pkg::wb_rsp_t      data_rsp_o,
    output logic                     mtip_o
);

    import wb_bus_pkg::*;
    import soc_map_pkg::*;

    logic [NUM_DATA_SLAVES-1:0] slv_stb;
    logic [NUM_DATA_SLAVES:0]   sel_q;
    wb_rsp_t                    ram_rsp;
    wb_rsp_t                    tmr_rsp;

    // data-port slave selection
    wb_addr_decode u_decode (
        .wb_clk_i  (wb_clk_i),
        .arst_n_i  (arst_n_i),
        .req_i     (data_req_i),
        .slv_stb_o (slv_stb),
        .sel_q_o   (sel_q)
    );

    // port 0 fetches, port 1 loads and stores
    wb_dual_port_ram u_ram (
        .wb_clk_i (wb_clk_i),
        .arst_n_i (arst_n_i),
        .p0_req_i (inst_req_i),
        .p0_rsp_o (inst_rsp_o),
        .p1_stb_i (slv_stb[SLV_RAM]),
        .p1_req_i (data_req_i),
        .p1_rsp_o (ram_rsp)
    );

    wb_mtime_regs u_mtime (
        .wb_clk_i (wb_clk_i),
        .arst_n_i (arst_n_i),
        .stb_i    (slv_stb[SLV_TIMER]),
        .req_i    (data_req_i),
        .rsp_o    (tmr_rsp),
        .mtip_o   (mtip_o)
    );

    // single response back to the data master
    wb_resp_mux u_resp_mux (
        .sel_q_i   (sel_q),
        .ram_rsp_i (ram_rsp),
        .tmr_rsp_i (tmr_rsp),
        .rsp_o     (data_rsp_o)
    );

endmodule

`default_nettype wire

/* verification/wb_soc_model.svh */
`ifndef WB_SOC_MODEL_SVH
`define WB_SOC_MODEL_SVH

// reference state, the RAM image only holds words the data port has touched
logic [31:0] lfsr_state;
logic [31:0] ram_img [int];
logic [3:0]  ram_known [int];
logic [63:0] mtime_m;
logic [63:0] mtimecmp_m;

// responses expected one cycle after the request, masks mark the known bits
wb_rsp_t     exp_data;
logic [31:0] exp_data_mask;
wb_rsp_t     exp_inst;
logic [31:0] exp_inst_mask;
logic        exp_mtip;

// 32-bit Galois LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0])
        n = n ^ 32'h8020_0003;
    return n;
endfunction

// one LFSR step per bit handed out
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
        lfsr_state = lfsr_step(lfsr_state);
        r = {r[30:0], lfsr_state[0]};
    end
    return r;
endfunction

function automatic logic [31:0] lane_mask(input logic [3:0] sel);
    logic [31:0] m;
    for (int b = 0; b < 4; b++)
        m[8*b +: 8] = {8{sel[b]}};
    return m;
endfunction

task automatic reset_model();
    ram_img.delete();
    ram_known.delete();
    mtime_m  = '0;
    mtimecmp_m = '1;
    exp_mtip = 1'b0;
    // both ports silent, data port returns zeros, fetch data unknown
    exp_data      = '0;
    exp_data_mask = '1;
    exp_inst      = '0;
    exp_inst_mask = '0;
endtask

// what the subsystem does at one rising edge, given the requests before it
task automatic predict_edge(input wb_req_t dreq, input wb_req_t ireq);
    logic [31:0] m;
    logic [31:0] old_w;
    logic [3:0]  old_k;
    logic [3:0]  ofs;
    logic [63:0] next_mtime;
    int          idx;
    exp_mtip      = (mtime_m >= mtimecmp_m);
    next_mtime    = mtime_m + 64'd1;
    exp_data      = '0;
    exp_data_mask = '1;
    exp_inst      = '0;
    exp_inst_mask = '0;
    if (ireq.cyc && ireq.stb)
    begin
        idx = int'((ireq.adr - RESET_VECTOR) >> 2);
        if (ireq.adr >= RESET_VECTOR && ireq.adr <= CODE_END)
        begin
            exp_inst.ack = 1'b1;
            if (ram_img.exists(idx))
            begin
                exp_inst.dat  = ram_img[idx];
                exp_inst_mask = lane_mask(ram_known[idx]);
            end
        end
        else
        begin
            exp_inst.err  = 1'b1;
            exp_inst_mask = '1;
        end
    end
    if (dreq.cyc && dreq.stb)
    begin
        m = lane_mask(dreq.sel);
        if (dreq.adr >= RESET_VECTOR && dreq.adr <= RAM_END)
        begin
            idx   = int'((dreq.adr - RESET_VECTOR) >> 2);
            old_w = ram_img.exists(idx) ? ram_img[idx] : 32'h0;
            old_k = ram_known.exists(idx) ? ram_known[idx] : 4'h0;
            exp_data.ack  = 1'b1;
            exp_data.dat  = old_w;
            exp_data_mask = lane_mask(old_k);
            if (dreq.we)
            begin
                ram_img[idx]   = (old_w & ~m) | (dreq.dat & m);
                ram_known[idx] = old_k | dreq.sel;
            end
        end
        else if (dreq.adr >= TIMER_BASE && dreq.adr <= TIMER_END)
        begin
            ofs = {dreq.adr[3:2], 2'b00};
            exp_data.ack = 1'b1;
            case (ofs)
                MTIME_LO_OFS:    exp_data.dat = mtime_m[31:0];
                MTIME_HI_OFS:    exp_data.dat = mtime_m[63:32];
                MTIMECMP_LO_OFS: exp_data.dat = mtimecmp_m[31:0];
                default:         exp_data.dat = mtimecmp_m[63:32];
            endcase
            if (dreq.we)
            begin
                // a write to mtime takes the place of that edge's increment
                case (ofs)
                    MTIME_LO_OFS:
                        next_mtime[31:0] = (mtime_m[31:0] & ~m) | (dreq.dat & m);
                    MTIME_HI_OFS:
                        next_mtime = {(mtime_m[63:32] & ~m) | (dreq.dat & m), mtime_m[31:0]};
                    MTIMECMP_LO_OFS:
                        mtimecmp_m[31:0] = (mtimecmp_m[31:0] & ~m) | (dreq.dat & m);
                    default:
                        mtimecmp_m[63:32] = (mtimecmp_m[63:32] & ~m) | (dreq.dat & m);
                endcase
                if (ofs == MTIME_LO_OFS)
                    next_mtime[63:32] = mtime_m[63:32];
            end
        end
        else
        begin
            exp_data.err = 1'b1;
        end
    end
    mtime_m = next_mtime;
endtask

`endif

/* verification/wb_soc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_soc_tb;

    import wb_bus_pkg::*;
    import soc_map_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int NUM_CYCLES   = 2000;
    localparam int CYCLE_LIMIT  = NUM_CYCLES + NUM_CYCLES / 20;

    logic    wb_clk_i;
    logic    arst_n_i;
    wb_req_t inst_req;
    wb_rsp_t inst_rsp;
    wb_req_t data_req;
    wb_rsp_t data_rsp;
    logic    mtip;

    int error_count;
    int check_count;
    int cycle_count;

    `include "wb_soc_model.svh"

    wb_soc_top uut (
        .wb_clk_i   (wb_clk_i),
        .arst_n_i   (arst_n_i),
        .inst_req_i (inst_req),
        .inst_rsp_o (inst_rsp),
        .data_req_i (data_req),
        .data_rsp_o (data_rsp),
        .mtip_o     (mtip)
    );

    always #50 wb_clk_i = ~wb_clk_i;

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("CHECK FAILED %s expected %h actual %h at cycle %0d",
                 name, exp, act, cycle_count);
        error_count++;
    endtask

    // word addresses straddling the end of the code window
    function automatic logic [31:0] ram_test_addr();
        logic [31:0] word;
        word = 32'h1BE0 + rand_bits(6);
        return RESET_VECTOR + (word << 2);
    endfunction

    function automatic logic [31:0] unmapped_addr();
        logic [1:0] area;
        area = rand_bits(2);
        case (area)
            2'd0:    return rand_bits(8) << 2;
            2'd1:    return TIMER_END + 32'd1 + (rand_bits(4) << 2);
            2'd2:    return RAM_END + 32'd1 + (rand_bits(8) << 2);
            default: return 32'hF000_0000 | (rand_bits(8) << 2);
        endcase
    endfunction

    // half data requests, a quarter fetches, the rest idle
    task automatic drive_random_request();
        logic [2:0] kind;
        logic [1:0] target;
        kind     = rand_bits(3);
        data_req = '0;
        inst_req = '0;
        if (kind < 3'd4)
        begin
            data_req.cyc = 1'b1;
            data_req.stb = 1'b1;
            data_req.we  = rand_bits(1);
            data_req.sel = rand_bits(4);
            data_req.dat = rand_bits(32);
            target       = rand_bits(2);
            if (target < 2'd2)
                data_req.adr = ram_test_addr();
            else if (target == 2'd2)
            begin
                data_req.adr = TIMER_BASE + (rand_bits(2) << 2);
                // small upper halves and a low compare value near mtime
                if (data_req.adr[2])
                    data_req.dat = rand_bits(2);
                else
                    data_req.dat = mtime_m[31:0] + rand_bits(6);
            end
            else
                data_req.adr = unmapped_addr();
        end
        else if (kind < 3'd6)
        begin
            inst_req.cyc = 1'b1;
            inst_req.stb = 1'b1;
            inst_req.sel = '1;
            if (rand_bits(3) == 32'd0)
                inst_req.adr = RAM_END + 32'd1 + (rand_bits(4) << 2);
            else
                inst_req.adr = ram_test_addr();
        end
    endtask

    task automatic check_responses();
        if (data_rsp.ack !== exp_data.ack)
            report_mismatch("data_rsp_o.ack", exp_data.ack, data_rsp.ack);
        if (data_rsp.err !== exp_data.err)
            report_mismatch("data_rsp_o.err", exp_data.err, data_rsp.err);
        if (data_rsp.stall !== 1'b0)
            report_mismatch("data_rsp_o.stall", 32'h0, data_rsp.stall);
        if ((data_rsp.dat & exp_data_mask) !== (exp_data.dat & exp_data_mask))
            report_mismatch("data_rsp_o.dat", exp_data.dat, data_rsp.dat);
        if (inst_rsp.ack !== exp_inst.ack)
            report_mismatch("inst_rsp_o.ack", exp_inst.ack, inst_rsp.ack);
        if (inst_rsp.err !== exp_inst.err)
            report_mismatch("inst_rsp_o.err", exp_inst.err, inst_rsp.err);
        if (inst_rsp.stall !== 1'b0)
            report_mismatch("inst_rsp_o.stall", 32'h0, inst_rsp.stall);
        if ((inst_rsp.dat & exp_inst_mask) !== (exp_inst.dat & exp_inst_mask))
            report_mismatch("inst_rsp_o.dat", exp_inst.dat, inst_rsp.dat);
        if (mtip !== exp_mtip)
            report_mismatch("mtip_o", exp_mtip, mtip);
        check_count += 9;
    endtask

    // run length guard
    always @(posedge wb_clk_i)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    initial
    begin
        wb_clk_i    = 1'b0;
        arst_n_i    = 1'b0;
        inst_req    = '0;
        data_req    = '0;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        lfsr_state  = 32'd4;
        reset_model();
        repeat (RESET_CYCLES) @(posedge wb_clk_i);
        #5;
        arst_n_i = 1'b1;
        // everything quiet straight out of reset
        check_responses();
        for (int n = 0; n < NUM_CYCLES; n++)
        begin
            drive_random_request();
            @(posedge wb_clk_i);
            predict_edge(data_req, inst_req);
            #5;
            check_responses();
        end
        data_req = '0;
        inst_req = '0;
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire
